// File: design/aPingPong.sv
`timescale 1ns/100ps

module aPingPong (
    input  logic                                         clk,
    input  logic                                         writeEn,
    input  logic                                         writeBank,
    input  systolicPkg::kIdxT                            writeAddr,
    input  systolicPkg::residueT [systolicPkg::Rows-1:0] writeData,
    input  logic                                         readBank,
    input  systolicPkg::kIdxT                            readAddr,
    output systolicPkg::residueT [systolicPkg::Rows-1:0] readData
);

    // One A column per word, two banks
    systolicPkg::residueT [systolicPkg::Rows-1:0] mem [2][systolicPkg::InnerLen];
    logic writeInRange;

    always_ff @(posedge clk) begin
        if (writeEn) begin
            mem[writeBank][writeAddr] <= writeData;
        end
    end

    always_ff @(posedge clk) begin
        readData <= mem[readBank][readAddr];
    end

    always_comb begin
        writeInRange = 1'b1;
        for (int r = 0; r < systolicPkg::Rows; r++) begin
            if (writeData[r] >= systolicPkg::residueT'(systolicPkg::Modulus)) begin
                writeInRange = 1'b0;
            end
        end
    end

    // Host must only store reduced residues
    assert property (@(posedge clk) writeEn |-> writeInRange)
        else $error("aPingPong write of a residue not below the modulus");

endmodule

// File: design/bTile.hex
// Tile 0 rows 0 to 7 then tile 1 rows 0 to 7
// Eight 14-bit residues per line with column 0 in the low bits
2f4a6c19e8a5d39b4a7e25179c3d
1b96e3f2c75d8e4f1d2c683a5e71
0a517d84f2e9c61a583f9a4e8d26
29c43ea06d1fb75c4e93a05d4c8b
1e05a7c83b62f9ad6c14e58f2a97
2d78f1469e0c52863a8d7b209f45
0c3a5d92e7a41f088c51429b6a03
1a2e9b584f81d6a22e7cb8145d69
2b6d04e9a3c27f519d0a68381e84
0f19c8a65d4e2b97e16f3a0c8b52
2e8a4d31f6a90c5e7a24d9f64c18
1c46a9e28b0df5635e8a24619d7c
0d5ae27841c89a36850b54942e1d
2a916f08d3e5b84a1c7f85264a5b
1f608b492e9a6c15ad38f07e5c92
2c0e5a879f2be469085d783f6e40

// File: design/bTileRom.sv
`timescale 1ns/100ps

module bTileRom (
    input  logic                                         clk,
    input  systolicPkg::tileIdxT                         tile,
    input  systolicPkg::kIdxT                            rowAddr,
    output systolicPkg::residueT [systolicPkg::Cols-1:0] rowData
);

    // One B row per line, column 0 in the low bits
    systolicPkg::residueT [systolicPkg::Cols-1:0] rom
        [systolicPkg::NumTiles * systolicPkg::InnerLen];

    initial begin
        $readmemh("design/bTile.hex", rom);
    end

    always_ff @(posedge clk) begin
        rowData <= rom[{tile, rowAddr}];
    end

endmodule

// File: design/macCell.sv
`timescale 1ns/100ps

module macCell (
    input  logic                 clk,
    input  logic                 srstn,
    input  systolicPkg::residueT aIn,
    input  systolicPkg::residueT bIn,
    input  logic                 validIn,
    input  logic                 firstIn,
    output systolicPkg::residueT aOut,
    output systolicPkg::residueT bOut,
    output logic                 validOut,
    output logic                 firstOut,
    output systolicPkg::residueT sum
);

    systolicPkg::residueT              aReg;
    systolicPkg::residueT              bReg;
    systolicPkg::residueT              product;
    logic                              validReg;
    logic                              firstReg;
    logic [systolicPkg::MulDelay-1:0]  validPipe;
    logic [systolicPkg::MulDelay-1:0]  firstPipe;
    logic [systolicPkg::DataWidth:0]   addWide;

    always_ff @(posedge clk) begin
        aReg <= aIn;
        bReg <= bIn;
    end

    // Flags follow the product through the multiplier
    always_ff @(posedge clk) begin
        if (!srstn) begin
            validReg <= 1'b0;
            firstReg <= 1'b0;
            validPipe <= '0;
            firstPipe <= '0;
        end else begin
            validReg <= validIn;
            firstReg <= firstIn;
            validPipe <= {validPipe[systolicPkg::MulDelay-2:0], validReg};
            firstPipe <= {firstPipe[systolicPkg::MulDelay-2:0], firstReg};
        end
    end

    modMult u_modMult (
        .clk(clk),
        .a(aReg),
        .b(bReg),
        .product(product)
    );

    assign addWide = sum + product;

    always_ff @(posedge clk) begin
        if (validPipe[systolicPkg::MulDelay-1]) begin
            if (firstPipe[systolicPkg::MulDelay-1]) begin
                sum <= product;
            end else if (addWide >= systolicPkg::Modulus) begin
                sum <= systolicPkg::residueT'(addWide - systolicPkg::Modulus);
            end else begin
                sum <= systolicPkg::residueT'(addWide);
            end
        end
    end

    assign aOut = aReg;
    assign bOut = bReg;
    assign validOut = validReg;
    assign firstOut = firstReg;

endmodule

// File: design/modMult.sv
`timescale 1ns/100ps

module modMult (
    input  logic                 clk,
    input  systolicPkg::residueT a,
    input  systolicPkg::residueT b,
    output systolicPkg::residueT product
);

    // Raw product, extra stages here absorb any MulDelay above four
    logic [2*systolicPkg::DataWidth-1:0] prodPipe [systolicPkg::MulDelay-3];
    logic [2*systolicPkg::DataWidth-1:0] xHold;
    systolicPkg::residueT                qEst;
    logic [systolicPkg::DataWidth:0]     rem;

    always_ff @(posedge clk) begin
        prodPipe[0] <= a * b;
        for (int i = 1; i < systolicPkg::MulDelay - 3; i++) begin
            prodPipe[i] <= prodPipe[i-1];
        end
    end

    // Quotient estimate is low by at most one
    always_ff @(posedge clk) begin
        xHold <= prodPipe[systolicPkg::MulDelay-4];
        qEst <= systolicPkg::residueT'(
            (64'(prodPipe[systolicPkg::MulDelay-4]) * 64'(systolicPkg::BarrettFactor))
            >> systolicPkg::BarrettShift);
    end

    // Remainder lands below twice the modulus
    always_ff @(posedge clk) begin
        rem <= (systolicPkg::DataWidth+1)'(xHold - qEst * systolicPkg::Modulus);
    end

    always_ff @(posedge clk) begin
        if (rem >= systolicPkg::Modulus) begin
            product <= systolicPkg::residueT'(rem - systolicPkg::Modulus);
        end else begin
            product <= systolicPkg::residueT'(rem);
        end
    end

endmodule

// File: design/operandIf.sv
`timescale 1ns/100ps

interface operandIf;

    systolicPkg::residueT [systolicPkg::Rows-1:0] aCol;
    systolicPkg::residueT [systolicPkg::Cols-1:0] bRow;
    logic opValid;
    // Step 0 of a tile, restarts the accumulators
    logic opFirst;

    modport seq (
        output aCol, bRow, opValid, opFirst
    );

    modport array (
        input aCol, bRow, opValid, opFirst
    );

endinterface

// File: design/outPingPong.sv
`timescale 1ns/100ps

module outPingPong (
    input  logic                                                                clk,
    input  logic                                                                capture,
    input  logic                                                                captureBank,
    input  systolicPkg::residueT [systolicPkg::Rows-1:0][systolicPkg::Cols-1:0] sums,
    input  logic                                                                readBank,
    input  systolicPkg::rowIdxT                                                 readAddr,
    output systolicPkg::residueT [systolicPkg::Cols-1:0]                        outRow
);

    // Whole result tile per bank
    systolicPkg::residueT [systolicPkg::Rows-1:0][systolicPkg::Cols-1:0] bank [2];

    always_ff @(posedge clk) begin
        if (capture) begin
            bank[captureBank] <= sums;
        end
    end

    always_ff @(posedge clk) begin
        outRow <= bank[readBank][readAddr];
    end

endmodule

// File: design/systolicArray.sv
`timescale 1ns/100ps

module systolicArray (
    input  logic clk,
    input  logic srstn,
    operandIf.array ops,
    output wire systolicPkg::residueT [systolicPkg::Rows-1:0][systolicPkg::Cols-1:0] sums
);

    // Delay line taps, entry d holds the step from d+1 cycles ago
    systolicPkg::residueT [systolicPkg::Rows-1:0] aDly [systolicPkg::Rows-1];
    systolicPkg::residueT [systolicPkg::Cols-1:0] bDly [systolicPkg::Cols-1];
    logic [systolicPkg::Rows-2:0] validDly;
    logic [systolicPkg::Rows-2:0] firstDly;

    // A and flags run right, B runs down
    wire systolicPkg::residueT aLink [systolicPkg::Rows][systolicPkg::Cols+1];
    wire systolicPkg::residueT bLink [systolicPkg::Rows+1][systolicPkg::Cols];
    wire validLink [systolicPkg::Rows][systolicPkg::Cols+1];
    wire firstLink [systolicPkg::Rows][systolicPkg::Cols+1];

    always_ff @(posedge clk) begin
        aDly[0] <= ops.aCol;
        bDly[0] <= ops.bRow;
        for (int d = 1; d < systolicPkg::Rows - 1; d++) begin
            aDly[d] <= aDly[d-1];
        end
        for (int d = 1; d < systolicPkg::Cols - 1; d++) begin
            bDly[d] <= bDly[d-1];
        end
    end

    always_ff @(posedge clk) begin
        if (!srstn) begin
            validDly <= '0;
            firstDly <= '0;
        end else begin
            validDly <= {validDly[systolicPkg::Rows-3:0], ops.opValid};
            firstDly <= {firstDly[systolicPkg::Rows-3:0], ops.opFirst};
        end
    end

    for (genvar r = 0; r < systolicPkg::Rows; r++) begin : gRowEdge
        if (r == 0) begin : gDirect
            assign aLink[r][0] = ops.aCol[r];
            assign validLink[r][0] = ops.opValid;
            assign firstLink[r][0] = ops.opFirst;
        end else begin : gSkewed
            assign aLink[r][0] = aDly[r-1][r];
            assign validLink[r][0] = validDly[r-1];
            assign firstLink[r][0] = firstDly[r-1];
        end
    end

    for (genvar c = 0; c < systolicPkg::Cols; c++) begin : gColEdge
        if (c == 0) begin : gDirect
            assign bLink[0][c] = ops.bRow[c];
        end else begin : gSkewed
            assign bLink[0][c] = bDly[c-1][c];
        end
    end

    for (genvar r = 0; r < systolicPkg::Rows; r++) begin : gRow
        for (genvar c = 0; c < systolicPkg::Cols; c++) begin : gCol
            macCell u_macCell (
                .clk(clk),
                .srstn(srstn),
                .aIn(aLink[r][c]),
                .bIn(bLink[r][c]),
                .validIn(validLink[r][c]),
                .firstIn(firstLink[r][c]),
                .aOut(aLink[r][c+1]),
                .bOut(bLink[r+1][c]),
                .validOut(validLink[r][c+1]),
                .firstOut(firstLink[r][c+1]),
                .sum(sums[r][c])
            );
        end
    end

endmodule

// File: design/systolicMm.sv
`timescale 1ns/100ps

module systolicMm (
    input  logic                                         clk,
    input  logic                                         srstn,
    input  logic                                         aWriteEn,
    input  logic                                         aWriteBank,
    input  systolicPkg::kIdxT                            aWriteAddr,
    input  systolicPkg::residueT [systolicPkg::Rows-1:0] aVec,
    input  logic                                         start,
    input  systolicPkg::tileIdxT                         tileSel,
    input  logic                                         outBank,
    input  logic                                         readBank,
    input  systolicPkg::rowIdxT                          readAddr,
    output logic                                         busy,
    output logic                                         done,
    output systolicPkg::residueT [systolicPkg::Cols-1:0] outRow
);

    systolicPkg::residueT [systolicPkg::Rows-1:0] aData;
    systolicPkg::residueT [systolicPkg::Cols-1:0] bData;
    logic aReadBank;
    systolicPkg::kIdxT aReadAddr;
    systolicPkg::tileIdxT romTile;
    systolicPkg::kIdxT romRow;
    logic capture;
    logic captureBank;
    wire systolicPkg::residueT [systolicPkg::Rows-1:0][systolicPkg::Cols-1:0] sums;

    operandIf opBus ();

    aPingPong u_aPingPong (
        .clk(clk),
        .writeEn(aWriteEn),
        .writeBank(aWriteBank),
        .writeAddr(aWriteAddr),
        .writeData(aVec),
        .readBank(aReadBank),
        .readAddr(aReadAddr),
        .readData(aData)
    );

    bTileRom u_bTileRom (
        .clk(clk),
        .tile(romTile),
        .rowAddr(romRow),
        .rowData(bData)
    );

    tileSequencer u_tileSequencer (
        .clk(clk),
        .srstn(srstn),
        .start(start),
        .tileSel(tileSel),
        .aWriteBank(aWriteBank),
        .outBank(outBank),
        .aData(aData),
        .bData(bData),
        .aReadBank(aReadBank),
        .aReadAddr(aReadAddr),
        .romTile(romTile),
        .romRow(romRow),
        .capture(capture),
        .captureBank(captureBank),
        .busy(busy),
        .done(done),
        .ops(opBus.seq)
    );

    systolicArray u_systolicArray (
        .clk(clk),
        .srstn(srstn),
        .ops(opBus.array),
        .sums(sums)
    );

    outPingPong u_outPingPong (
        .clk(clk),
        .capture(capture),
        .captureBank(captureBank),
        .sums(sums),
        .readBank(readBank),
        .readAddr(readAddr),
        .outRow(outRow)
    );

endmodule

// File: design/systolicPkg.sv
package systolicPkg;

    // Array geometry
    localparam int Rows = 4;
    localparam int Cols = 8;
    localparam int InnerLen = 8;
    localparam int NumTiles = 2;

    // Residue arithmetic
    localparam int DataWidth = 14;
    localparam int Modulus = 12289;
    localparam int MulDelay = 4;

    // Last operand step until the far corner cell holds its final sum
    localparam int DrainCycles = Rows + Cols + MulDelay + 2;

    // Barrett reduction constants for products below 2^(2*DataWidth)
    localparam int BarrettShift = 2 * DataWidth;
    localparam int BarrettFactor = (1 << BarrettShift) / Modulus;

    typedef logic [DataWidth-1:0] residueT;
    typedef logic [2:0] kIdxT;
    typedef logic [0:0] tileIdxT;
    typedef logic [1:0] rowIdxT;

    typedef enum logic [1:0] {
        Idle,
        Feed,
        Drain,
        Capture
    } seqStateT;

endpackage

// File: design/tileSequencer.sv
`timescale 1ns/100ps

module tileSequencer (
    input  logic                                         clk,
    input  logic                                         srstn,
    input  logic                                         start,
    input  systolicPkg::tileIdxT                         tileSel,
    input  logic                                         aWriteBank,
    input  logic                                         outBank,
    input  systolicPkg::residueT [systolicPkg::Rows-1:0] aData,
    input  systolicPkg::residueT [systolicPkg::Cols-1:0] bData,
    output logic                                         aReadBank,
    output systolicPkg::kIdxT                            aReadAddr,
    output systolicPkg::tileIdxT                         romTile,
    output systolicPkg::kIdxT                            romRow,
    output logic                                         capture,
    output logic                                         captureBank,
    output logic                                         busy,
    output logic                                         done,
    operandIf.seq                                        ops
);

    systolicPkg::seqStateT state;
    systolicPkg::kIdxT kIdx;
    logic [$clog2(systolicPkg::DrainCycles)-1:0] drainCnt;
    logic issue;

    assign issue = (state == systolicPkg::Feed);

    always_ff @(posedge clk) begin
        if (!srstn) begin
            state <= systolicPkg::Idle;
            kIdx <= '0;
            drainCnt <= '0;
            aReadBank <= 1'b0;
            romTile <= '0;
            captureBank <= 1'b0;
        end else begin
            case (state)
                systolicPkg::Idle: begin
                    // Compute from the bank the host is not writing
                    if (start) begin
                        aReadBank <= ~aWriteBank;
                        romTile <= tileSel;
                        captureBank <= outBank;
                        kIdx <= '0;
                        state <= systolicPkg::Feed;
                    end
                end
                systolicPkg::Feed: begin
                    kIdx <= kIdx + 1'b1;
                    if (kIdx == systolicPkg::kIdxT'(systolicPkg::InnerLen - 1)) begin
                        drainCnt <= '0;
                        state <= systolicPkg::Drain;
                    end
                end
                systolicPkg::Drain: begin
                    drainCnt <= drainCnt + 1'b1;
                    if (drainCnt == $bits(drainCnt)'(systolicPkg::DrainCycles - 1)) begin
                        state <= systolicPkg::Capture;
                    end
                end
                default: begin
                    state <= systolicPkg::Idle;
                end
            endcase
        end
    end

    // Memories answer one cycle after the address, so the flags wait one cycle
    always_ff @(posedge clk) begin
        if (!srstn) begin
            ops.opValid <= 1'b0;
            ops.opFirst <= 1'b0;
            done <= 1'b0;
        end else begin
            ops.opValid <= issue;
            ops.opFirst <= issue && (kIdx == '0);
            done <= capture;
        end
    end

    assign ops.aCol = aData;
    assign ops.bRow = bData;
    assign aReadAddr = kIdx;
    assign romRow = kIdx;
    assign capture = (state == systolicPkg::Capture);
    assign busy = (state != systolicPkg::Idle);

    assert property (@(posedge clk) disable iff (!srstn) done |=> !done)
        else $error("done held for more than one cycle");

    assert property (@(posedge clk) disable iff (!srstn) capture |-> busy ##1 (done && !busy))
        else $error("capture outside a run or not followed by done");

endmodule

// File: dv/tbSystolicMm.sv
`timescale 1ns/100ps

module tbSystolicMm;

    typedef systolicPkg::residueT [systolicPkg::Cols-1:0] rowT;

    localparam int RunTimeout = 4 * (systolicPkg::InnerLen + systolicPkg::DrainCycles) + 16;

    logic clk;
    logic srstn;
    logic aWriteEn;
    logic aWriteBank;
    systolicPkg::kIdxT aWriteAddr;
    systolicPkg::residueT [systolicPkg::Rows-1:0] aVec;
    logic start;
    systolicPkg::tileIdxT tileSel;
    logic outBank;
    logic readBank;
    systolicPkg::rowIdxT readAddr;
    logic busy;
    logic done;
    rowT outRow;

    // Host side copies of the A banks, the B ROM and the output banks
    systolicPkg::residueT aModel [2][systolicPkg::Rows][systolicPkg::InnerLen];
    rowT bModel [systolicPkg::NumTiles * systolicPkg::InnerLen];
    rowT expOut [2][systolicPkg::Rows];

    // Parameters of the run in flight
    int runABank;
    int runTile;
    int runOutBank;

    // Read requests waiting for the compare process
    rowT expQ [$];
    string tagQ [$];
    logic readReq;
    logic rowCheckDue;
    rowT cmpRow;
    string cmpTag;

    systolicMm u_systolicMm (
        .clk(clk),
        .srstn(srstn),
        .aWriteEn(aWriteEn),
        .aWriteBank(aWriteBank),
        .aWriteAddr(aWriteAddr),
        .aVec(aVec),
        .start(start),
        .tileSel(tileSel),
        .outBank(outBank),
        .readBank(readBank),
        .readAddr(readAddr),
        .busy(busy),
        .done(done),
        .outRow(outRow)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    task automatic failRun();
        $display("tests failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic checkResidue(input systolicPkg::residueT got,
                                input systolicPkg::residueT exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s got %0d expected %0d", $time, what, got, exp);
            failRun();
        end
    endtask

    task automatic checkBit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s got %b expected %b", $time, what, got, exp);
            failRun();
        end
    endtask

    // Sum over k of A[r][k] * B[k][c], reduced once at the end
    function automatic systolicPkg::residueT refElem(input int bank, input int tile,
                                                     input int r, input int c);
        longint acc;
        acc = 0;
        for (int k = 0; k < systolicPkg::InnerLen; k++) begin
            acc += longint'(aModel[bank][r][k]) *
                   longint'(bModel[tile * systolicPkg::InnerLen + k][c]);
        end
        return systolicPkg::residueT'(acc % systolicPkg::Modulus);
    endfunction

    task automatic loadA(input logic bank, input bit allMax);
        systolicPkg::residueT [systolicPkg::Rows-1:0] col;
        for (int k = 0; k < systolicPkg::InnerLen; k++) begin
            for (int r = 0; r < systolicPkg::Rows; r++) begin
                if (allMax) begin
                    col[r] = systolicPkg::residueT'(systolicPkg::Modulus - 1);
                end else begin
                    col[r] = systolicPkg::residueT'($urandom % systolicPkg::Modulus);
                end
                aModel[bank][r][k] = col[r];
            end
            @(posedge clk);
            aWriteEn <= 1'b1;
            aWriteBank <= bank;
            aWriteAddr <= systolicPkg::kIdxT'(k);
            aVec <= col;
        end
        @(posedge clk);
        aWriteEn <= 1'b0;
    endtask

    // Compute bank is the inverse of aWriteBank at start
    task automatic startRun(input logic aBank, input systolicPkg::tileIdxT tile,
                            input logic oBank);
        @(negedge clk);
        checkBit(busy, 1'b0, "busy before start");
        @(posedge clk);
        start <= 1'b1;
        tileSel <= tile;
        outBank <= oBank;
        aWriteBank <= ~aBank;
        runABank = aBank;
        runTile = tile;
        runOutBank = oBank;
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic finishRun();
        int cycles;
        bit seen;
        cycles = 0;
        seen = 1'b0;
        while (!seen) begin
            @(negedge clk);
            if (done) begin
                seen = 1'b1;
                checkBit(busy, 1'b0, "busy in the done cycle");
            end else begin
                checkBit(busy, 1'b1, "busy during the run");
                cycles++;
                if (cycles > RunTimeout) begin
                    $display("Timeout: no done pulse within %0d cycles", RunTimeout);
                    failRun();
                end
            end
        end
        for (int r = 0; r < systolicPkg::Rows; r++) begin
            for (int c = 0; c < systolicPkg::Cols; c++) begin
                expOut[runOutBank][r][c] = refElem(runABank, runTile, r, c);
            end
        end
    endtask

    task automatic checkBank(input logic bank);
        for (int r = 0; r < systolicPkg::Rows; r++) begin
            @(posedge clk);
            readReq <= 1'b1;
            readBank <= bank;
            readAddr <= systolicPkg::rowIdxT'(r);
            expQ.push_back(expOut[bank][r]);
            tagQ.push_back($sformatf("bank %0d row %0d", bank, r));
        end
        @(posedge clk);
        readReq <= 1'b0;
    endtask

    task automatic drainCompare();
        int cycles;
        cycles = 0;
        while (expQ.size() != 0) begin
            @(posedge clk);
            cycles++;
            if (cycles > RunTimeout) begin
                $display("Timeout: compare process still holds %0d rows", expQ.size());
                failRun();
            end
        end
    endtask

    // outRow answers one cycle after the address
    always @(posedge clk) begin
        if (!srstn) begin
            rowCheckDue <= 1'b0;
        end else begin
            rowCheckDue <= readReq;
        end
    end

    always @(negedge clk) begin
        if (rowCheckDue) begin
            if (expQ.size() == 0) begin
                $display("Output row arrived with no expected row queued");
                failRun();
            end else begin
                cmpRow = expQ.pop_front();
                cmpTag = tagQ.pop_front();
                for (int c = 0; c < systolicPkg::Cols; c++) begin
                    checkResidue(outRow[c], cmpRow[c], $sformatf("%s col %0d", cmpTag, c));
                end
            end
        end
    end

    initial begin
        void'($urandom(86035));
        $readmemh("design/bTile.hex", bModel);
        srstn = 1'b0;
        aWriteEn = 1'b0;
        aWriteBank = 1'b0;
        aWriteAddr = '0;
        aVec = '0;
        start = 1'b0;
        tileSel = '0;
        outBank = 1'b0;
        readBank = 1'b0;
        readAddr = '0;
        readReq = 1'b0;
        repeat (10) @(posedge clk);
        srstn <= 1'b1;

        repeat (6) begin
            @(negedge clk);
            checkBit(busy, 1'b0, "busy after reset");
            checkBit(done, 1'b0, "done after reset");
        end

        loadA(1'b0, 1'b0);
        startRun(1'b0, 1'b0, 1'b0);
        finishRun();
        checkBank(1'b0);

        // All residues at Modulus - 1
        loadA(1'b1, 1'b1);
        startRun(1'b1, 1'b1, 1'b0);
        finishRun();
        checkBank(1'b0);

        // Bank 1 refilled while bank 0 feeds the array
        loadA(1'b0, 1'b0);
        startRun(1'b0, 1'b0, 1'b0);
        loadA(1'b1, 1'b0);
        finishRun();
        checkBank(1'b0);
        startRun(1'b1, 1'b1, 1'b1);
        finishRun();
        checkBank(1'b1);

        loadA(1'b0, 1'b0);
        startRun(1'b0, 1'b1, 1'b1);
        finishRun();
        checkBank(1'b0);
        checkBank(1'b1);

        // Second request during the run must be dropped
        startRun(1'b1, 1'b0, 1'b0);
        repeat (2) @(posedge clk);
        start <= 1'b1;
        tileSel <= systolicPkg::tileIdxT'(1);
        outBank <= 1'b1;
        aWriteBank <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        finishRun();
        repeat (RunTimeout) begin
            @(negedge clk);
            checkBit(done, 1'b0, "done after the single run");
            checkBit(busy, 1'b0, "busy after the single run");
        end
        checkBank(1'b0);
        checkBank(1'b1);

        drainCompare();
        $display("all tests passed");
        $finish;
    end

endmodule

// File: systolicMm.f
design/systolicPkg.sv
design/operandIf.sv
design/aPingPong.sv
design/bTileRom.sv
design/modMult.sv
design/macCell.sv
design/systolicArray.sv
design/tileSequencer.sv
design/outPingPong.sv
design/systolicMm.sv
dv/tbSystolicMm.sv
